/* source/i3c_tx_pkg.sv */
// Widths, queue depths, descriptor layout and byte beat for the TTI TX path

package i3c_tx_pkg;

  // Word widths
  localparam int unsigned DescWidth    = 32;
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned BytesPerWord = 4;
  localparam int unsigned ByteWidth    = DataWidth / BytesPerWord;
  localparam int unsigned ByteIdxWidth = $clog2(BytesPerWord);

  // Length field of a descriptor, in bytes
  localparam int unsigned LenWidth = 16;

  // Descriptor queue
  localparam int unsigned DescDepth    = 4;
  localparam int unsigned DescPtrWidth = $clog2(DescDepth);
  localparam int unsigned DescCntWidth = $clog2(DescDepth + 1);

  // Data word FIFO
  localparam int unsigned DataDepth    = 16;
  localparam int unsigned DataPtrWidth = $clog2(DataDepth);
  localparam int unsigned DataCntWidth = $clog2(DataDepth + 1);

  // Depth count reported towards the descriptor handler
  localparam int unsigned DepthWidth = 16;

  // TX descriptor word as pushed by software
  typedef struct packed {
    logic [DescWidth-LenWidth-1:0] reserved;
    logic [LenWidth-1:0]           data_len;
  } tx_desc_t;

  // One byte towards the target bus FSM
  typedef struct packed {
    logic [ByteWidth-1:0] data;
    logic                 last;
  } tx_beat_t;

endpackage

/* source/tx_desc_queue.sv */
// TX descriptor FIFO with valid/ready push and pop sides

`timescale 1ns/1ps

module tx_desc_queue (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // Push side
  input  logic                 wvalid_i,
  output logic                 wready_o,
  input  i3c_tx_pkg::tx_desc_t wdata_i,

  // Pop side, oldest entry
  output logic                 rvalid_o,
  input  logic                 rready_i,
  output i3c_tx_pkg::tx_desc_t rdata_o
);

  i3c_tx_pkg::tx_desc_t                     mem [i3c_tx_pkg::DescDepth];
  logic [i3c_tx_pkg::DescPtrWidth-1:0]      wptr;
  logic [i3c_tx_pkg::DescPtrWidth-1:0]      rptr;
  logic [i3c_tx_pkg::DescCntWidth-1:0]      count;
  logic                                     push;
  logic                                     pop;

  assign wready_o = count != i3c_tx_pkg::DescCntWidth'(i3c_tx_pkg::DescDepth);
  assign rvalid_o = count != '0;
  assign rdata_o  = mem[rptr];

  assign push = wvalid_i && wready_o;
  assign pop  = rvalid_o && rready_i;

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wptr] <= wdata_i;
    end
  end

  // Pointers wrap at the last entry
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr <= '0;
      rptr <= '0;
    end else begin
      if (push) begin
        wptr <= (wptr == i3c_tx_pkg::DescPtrWidth'(i3c_tx_pkg::DescDepth - 1)) ?
                '0 : wptr + 1'b1;
      end
      if (pop) begin
        rptr <= (rptr == i3c_tx_pkg::DescPtrWidth'(i3c_tx_pkg::DescDepth - 1)) ?
                '0 : rptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count <= '0;
    end else begin
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* source/tx_data_queue.sv */
// TX data word FIFO with depth count and a word-to-byte unpacker

`timescale 1ns/1ps

module tx_data_queue (
  input  logic                                clk_i,
  input  logic                                rst_ni,

  // Word push side
  input  logic                                wvalid_i,
  output logic                                wready_o,
  input  logic [i3c_tx_pkg::DataWidth-1:0]    wdata_i,

  // Words waiting in the FIFO, unpacker excluded
  output logic [i3c_tx_pkg::DepthWidth-1:0]   depth_o,

  // Byte pop side
  output logic                                byte_rvalid_o,
  input  logic                                byte_rready_i,
  output logic [i3c_tx_pkg::ByteWidth-1:0]    byte_rdata_o,
  input  logic                                word_drop_i
);

  logic [i3c_tx_pkg::DataWidth-1:0]    mem [i3c_tx_pkg::DataDepth];
  logic [i3c_tx_pkg::DataPtrWidth-1:0] wptr;
  logic [i3c_tx_pkg::DataPtrWidth-1:0] rptr;
  logic [i3c_tx_pkg::DataCntWidth-1:0] count;
  logic                                push;
  logic                                fifo_pop;

  logic [i3c_tx_pkg::DataWidth-1:0]    unp_word;
  logic [i3c_tx_pkg::ByteIdxWidth-1:0] unp_idx;
  logic                                unp_valid;
  logic                                word_done;
  logic                                unp_free;

  assign wready_o = count != i3c_tx_pkg::DataCntWidth'(i3c_tx_pkg::DataDepth);
  assign push     = wvalid_i && wready_o;
  assign depth_o  = i3c_tx_pkg::DepthWidth'(count);

  // Unpacker is done with its word after the final byte or on a drop
  assign word_done = unp_valid &&
                     (word_drop_i ||
                      (byte_rready_i &&
                       unp_idx == i3c_tx_pkg::ByteIdxWidth'(i3c_tx_pkg::BytesPerWord - 1)));
  assign unp_free  = !unp_valid || word_done;
  assign fifo_pop  = unp_free && (count != '0);

  // Little-endian, byte 0 first
  assign byte_rvalid_o = unp_valid;
  assign byte_rdata_o  = unp_word[unp_idx*i3c_tx_pkg::ByteWidth +: i3c_tx_pkg::ByteWidth];

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wptr] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wptr <= (wptr == i3c_tx_pkg::DataPtrWidth'(i3c_tx_pkg::DataDepth - 1)) ?
                '0 : wptr + 1'b1;
      end
      if (fifo_pop) begin
        rptr <= (rptr == i3c_tx_pkg::DataPtrWidth'(i3c_tx_pkg::DataDepth - 1)) ?
                '0 : rptr + 1'b1;
      end
      case ({push, fifo_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Word currently being unpacked
  always_ff @(posedge clk_i) begin
    if (fifo_pop) begin
      unp_word <= mem[rptr];
    end
  end

  // Reload on the same edge the old word finishes, if a word is waiting
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      unp_valid <= 1'b0;
      unp_idx   <= '0;
    end else begin
      if (fifo_pop) begin
        unp_valid <= 1'b1;
        unp_idx   <= '0;
      end else if (word_done) begin
        unp_valid <= 1'b0;
        unp_idx   <= '0;
      end else if (unp_valid && byte_rready_i) begin
        unp_idx <= unp_idx + 1'b1;
      end
    end
  end

endmodule

/* source/descriptor_tx.sv */
// TX descriptor handler with start gating, byte counter, last flag, end pulse and flush

`timescale 1ns/1ps

module descriptor_tx (
  input  logic                              clk_i,
  input  logic                              rst_ni,

  // Descriptor queue
  input  logic                              desc_rvalid_i,
  output logic                              desc_rready_o,
  input  i3c_tx_pkg::tx_desc_t              desc_rdata_i,

  // Data queue
  input  logic [i3c_tx_pkg::DepthWidth-1:0] word_depth_i,
  input  logic                              byte_rvalid_i,
  output logic                              byte_rready_o,
  input  logic [i3c_tx_pkg::ByteWidth-1:0]  byte_rdata_i,
  output logic                              word_drop_o,

  // Target bus FSM
  input  logic                              tx_start_i,
  input  logic                              tx_abort_i,
  input  logic                              recovery_mode_enter_i,
  output logic                              tx_desc_avail_o,
  output i3c_tx_pkg::tx_beat_t              tx_beat_o,
  output logic                              tx_byte_valid_o,
  input  logic                              tx_byte_ready_i,
  output logic                              tx_end_o
);

  i3c_tx_pkg::tx_desc_t              desc_q;
  logic                              desc_held;
  logic                              pending;
  logic                              flush;
  logic [i3c_tx_pkg::LenWidth-1:0]   byte_cnt;
  logic [i3c_tx_pkg::LenWidth-1:0]   data_len;
  logic [i3c_tx_pkg::DepthWidth:0]   avail_words;
  logic [i3c_tx_pkg::LenWidth:0]     len_words;
  logic                              abort_req;
  logic                              flush_enter;
  logic                              start;
  logic                              send_end;
  logic                              flush_pop;
  logic                              flush_done;
  logic                              empty_end;
  logic                              tx_end;

  assign abort_req = tx_abort_i || recovery_mode_enter_i;
  assign data_len  = desc_q.data_len;

  // Only take a new descriptor while idle and not aborting
  assign desc_rready_o   = !desc_held && tx_start_i && desc_rvalid_i && !flush && !abort_req;
  assign tx_desc_avail_o = desc_rvalid_i;

  // Length rounded up to whole words
  assign len_words   = ({1'b0, data_len} + (i3c_tx_pkg::LenWidth + 1)'(3)) >> 2;
  // Unpacker word counts when it holds data
  assign avail_words = {1'b0, word_depth_i} + (i3c_tx_pkg::DepthWidth + 1)'(byte_rvalid_i);

  assign start = desc_held && !pending && !flush && !abort_req &&
                 (avail_words >= (i3c_tx_pkg::DepthWidth + 1)'(len_words));

  // A transfer that ends in this cycle has nothing left to flush
  assign flush_enter = !flush && abort_req && (pending || desc_held) && !tx_end;

  always_ff @(posedge clk_i) begin
    if (desc_rready_o) begin
      desc_q <= desc_rdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      desc_held <= 1'b0;
    end else if (tx_end) begin
      desc_held <= 1'b0;
    end else if (desc_rready_o) begin
      desc_held <= 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending <= 1'b0;
    end else if (start) begin
      pending <= 1'b1;
    end else if (tx_end || flush_enter) begin
      pending <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flush <= 1'b0;
    end else if (flush_enter) begin
      flush <= 1'b1;
    end else if (flush_done) begin
      flush <= 1'b0;
    end
  end

  // Abort before sending started still has the whole length to discard
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      byte_cnt <= '0;
    end else if (start || (flush_enter && !pending)) begin
      byte_cnt <= data_len;
    end else if (byte_rready_o) begin
      byte_cnt <= byte_cnt - 1'b1;
    end
  end

  // Flush pops without presenting, ends early once data runs dry
  assign flush_pop  = flush && byte_rvalid_i && (byte_cnt != '0);
  assign flush_done = flush && (!byte_rvalid_i || byte_cnt <= i3c_tx_pkg::LenWidth'(1));

  assign tx_byte_valid_o = pending && !flush && byte_rvalid_i;
  assign tx_beat_o.data  = byte_rdata_i;
  assign tx_beat_o.last  = byte_cnt == i3c_tx_pkg::LenWidth'(1);

  assign byte_rready_o = (tx_byte_valid_o && tx_byte_ready_i) || flush_pop;

  assign send_end  = tx_byte_valid_o && tx_byte_ready_i && tx_beat_o.last;
  // Zero-length descriptor ends without a byte
  assign empty_end = pending && !flush && (byte_cnt == '0);
  assign tx_end    = send_end || flush_done || empty_end;
  assign tx_end_o  = tx_end;

  // Tail of a partial word never reaches the next transfer
  assign word_drop_o = tx_end && (data_len[1:0] != 2'b00);

endmodule

/* source/tti_tx_path.sv */
// Top level of the TTI TX path with descriptor queue, data queue and descriptor handler

`timescale 1ns/1ps

module tti_tx_path (
  input  logic                             clk_i,
  input  logic                             rst_ni,

  // Descriptor push
  input  logic                             desc_wvalid_i,
  output logic                             desc_wready_o,
  input  i3c_tx_pkg::tx_desc_t             desc_wdata_i,

  // Data push
  input  logic                             data_wvalid_i,
  output logic                             data_wready_o,
  input  logic [i3c_tx_pkg::DataWidth-1:0] data_wdata_i,

  // Target bus FSM
  input  logic                             tx_start_i,
  input  logic                             tx_abort_i,
  input  logic                             recovery_mode_enter_i,
  output logic                             tx_desc_avail_o,
  output i3c_tx_pkg::tx_beat_t             tx_beat_o,
  output logic                             tx_byte_valid_o,
  input  logic                             tx_byte_ready_i,
  output logic                             tx_end_o
);

  logic                              desc_rvalid;
  logic                              desc_rready;
  i3c_tx_pkg::tx_desc_t              desc_rdata;
  logic [i3c_tx_pkg::DepthWidth-1:0] word_depth;
  logic                              byte_rvalid;
  logic                              byte_rready;
  logic [i3c_tx_pkg::ByteWidth-1:0]  byte_rdata;
  logic                              word_drop;

  tx_desc_queue u_desc_queue (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (desc_wvalid_i),
    .wready_o (desc_wready_o),
    .wdata_i  (desc_wdata_i),
    .rvalid_o (desc_rvalid),
    .rready_i (desc_rready),
    .rdata_o  (desc_rdata)
  );

  tx_data_queue u_data_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .wvalid_i      (data_wvalid_i),
    .wready_o      (data_wready_o),
    .wdata_i       (data_wdata_i),
    .depth_o       (word_depth),
    .byte_rvalid_o (byte_rvalid),
    .byte_rready_i (byte_rready),
    .byte_rdata_o  (byte_rdata),
    .word_drop_i   (word_drop)
  );

  descriptor_tx u_descriptor_tx (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .desc_rvalid_i         (desc_rvalid),
    .desc_rready_o         (desc_rready),
    .desc_rdata_i          (desc_rdata),
    .word_depth_i          (word_depth),
    .byte_rvalid_i         (byte_rvalid),
    .byte_rready_o         (byte_rready),
    .byte_rdata_i          (byte_rdata),
    .word_drop_o           (word_drop),
    .tx_start_i            (tx_start_i),
    .tx_abort_i            (tx_abort_i),
    .recovery_mode_enter_i (recovery_mode_enter_i),
    .tx_desc_avail_o       (tx_desc_avail_o),
    .tx_beat_o             (tx_beat_o),
    .tx_byte_valid_o       (tx_byte_valid_o),
    .tx_byte_ready_i       (tx_byte_ready_i),
    .tx_end_o              (tx_end_o)
  );

endmodule

/* verif/tti_tx_path_asserts.sv */
// Bus FSM side protocol assertions for the TTI TX path, bound to the top level

`timescale 1ns/1ps

module tti_tx_path_asserts (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 tx_abort_i,
  input logic                 recovery_mode_enter_i,
  input i3c_tx_pkg::tx_beat_t tx_beat_o,
  input logic                 tx_byte_valid_o,
  input logic                 tx_byte_ready_i,
  input logic                 tx_end_o
);

  // Abort or recovery entry may withdraw a stalled byte
  property beat_stable_p;
    @(posedge clk_i) disable iff (!rst_ni)
      (tx_byte_valid_o && !tx_byte_ready_i && !tx_abort_i && !recovery_mode_enter_i)
      |=> (tx_byte_valid_o && $stable(tx_beat_o));
  endproperty

  property end_single_p;
    @(posedge clk_i) disable iff (!rst_ni)
      tx_end_o |=> !tx_end_o;
  endproperty

  property reset_quiet_p;
    @(posedge clk_i) !rst_ni |-> (!tx_byte_valid_o && !tx_end_o);
  endproperty

  beat_stable_a: assert property (beat_stable_p)
    else $error("Beat or valid changed while the byte was stalled");
  end_single_a: assert property (end_single_p)
    else $error("End pulse lasted more than one cycle");
  reset_quiet_a: assert property (reset_quiet_p)
    else $error("Byte valid or end seen during reset");

endmodule

bind tti_tx_path tti_tx_path_asserts u_asserts (
  .clk_i                 (clk_i),
  .rst_ni                (rst_ni),
  .tx_abort_i            (tx_abort_i),
  .recovery_mode_enter_i (recovery_mode_enter_i),
  .tx_beat_o             (tx_beat_o),
  .tx_byte_valid_o       (tx_byte_valid_o),
  .tx_byte_ready_i       (tx_byte_ready_i),
  .tx_end_o              (tx_end_o)
);

/* verif/tb_tti_tx_path.sv */
// Testbench for the TTI TX path with clock, reset, transfer table, queue loading, byte checks and watchdog

`timescale 1ns/1ps

module tb_tti_tx_path;

  localparam int NoAbort     = 65535;
  localparam int ResetCycles = 16;
  localparam int WaitWindow  = 20;

  // One row of the transfer table
  typedef struct packed {
    logic [15:0] len;
    logic [15:0] abort_after;
    logic [7:0]  stall_pct;
    logic        with_desc;
  } row_t;

  logic                             clk_i;
  logic                             rst_ni;
  logic                             desc_wvalid_i;
  logic                             desc_wready_o;
  i3c_tx_pkg::tx_desc_t             desc_wdata_i;
  logic                             data_wvalid_i;
  logic                             data_wready_o;
  logic [i3c_tx_pkg::DataWidth-1:0] data_wdata_i;
  logic                             tx_start_i;
  logic                             tx_abort_i;
  logic                             recovery_mode_enter_i;
  logic                             tx_desc_avail_o;
  i3c_tx_pkg::tx_beat_t             tx_beat_o;
  logic                             tx_byte_valid_o;
  logic                             tx_byte_ready_i;
  logic                             tx_end_o;

  row_t                             rows [$];
  string                            row_names [$];
  logic [i3c_tx_pkg::ByteWidth-1:0] model_q [$];
  logic [31:0]                      rng_state;

  always #5 clk_i = ~clk_i;

  tti_tx_path dut (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .desc_wvalid_i         (desc_wvalid_i),
    .desc_wready_o         (desc_wready_o),
    .desc_wdata_i          (desc_wdata_i),
    .data_wvalid_i         (data_wvalid_i),
    .data_wready_o         (data_wready_o),
    .data_wdata_i          (data_wdata_i),
    .tx_start_i            (tx_start_i),
    .tx_abort_i            (tx_abort_i),
    .recovery_mode_enter_i (recovery_mode_enter_i),
    .tx_desc_avail_o       (tx_desc_avail_o),
    .tx_beat_o             (tx_beat_o),
    .tx_byte_valid_o       (tx_byte_valid_o),
    .tx_byte_ready_i       (tx_byte_ready_i),
    .tx_end_o              (tx_end_o)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic report_mismatch(input string test, input string what,
                                 input logic [31:0] expected, input logic [31:0] actual);
    $display("[ERROR] %s: %s expected 0x%0h, actual 0x%0h", test, what, expected, actual);
    $display("Simulation failed");
    $fatal(1, "Value mismatch in %s", test);
  endtask

  task automatic report_failure(input string test, input string what);
    $display("[ERROR] %s: %s", test, what);
    $display("Simulation failed");
    $fatal(1, "Check failed in %s", test);
  endtask

  task automatic watchdog(input int cycles);
    repeat (cycles) begin
      @(posedge clk_i);
    end
    $display("[ERROR] watchdog: run did not finish within %0d cycles", cycles);
    $display("Simulation failed");
    $fatal(1, "Timeout");
  endtask

  task automatic add_row(input string name, input int len, input int abort_after,
                         input int stall_pct, input bit with_desc);
    row_t row;
    row.len         = 16'(len);
    row.abort_after = 16'(abort_after);
    row.stall_pct   = 8'(stall_pct);
    row.with_desc   = with_desc;
    rows.push_back(row);
    row_names.push_back(name);
  endtask

  // Name, length, abort after byte, ready stall percent, descriptor pushed
  task automatic load_table();
    add_row("len8_full",          8,  NoAbort, 0,  1'b1);
    add_row("len16_full",         16, NoAbort, 0,  1'b1);
    add_row("len5_tail",          5,  NoAbort, 0,  1'b1);
    add_row("len7_tail",          7,  NoAbort, 0,  1'b1);
    add_row("len1_tail",          1,  NoAbort, 0,  1'b1);
    add_row("len4_after_tail",    4,  NoAbort, 0,  1'b1);
    add_row("len32_stall",        32, NoAbort, 50, 1'b1);
    add_row("len13_stall",        13, NoAbort, 30, 1'b1);
    add_row("len12_abort3",       12, 3,       20, 1'b1);
    add_row("len8_after_abort",   8,  NoAbort, 0,  1'b1);
    add_row("len10_abort5",       10, 5,       0,  1'b1);
    add_row("start_no_desc",      0,  NoAbort, 0,  1'b0);
    add_row("len6_after_no_desc", 6,  NoAbort, 25, 1'b1);
    add_row("len64_stall",        64, NoAbort, 10, 1'b1);
  endtask

  task automatic push_descriptor(input logic [15:0] len);
    i3c_tx_pkg::tx_desc_t desc;
    desc          = '0;
    desc.data_len = len;
    @(posedge clk_i);
    desc_wvalid_i <= 1'b1;
    desc_wdata_i  <= desc;
    @(negedge clk_i);
    while (!desc_wready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    desc_wvalid_i <= 1'b0;
  endtask

  // Whole words go to the DUT, only the first len bytes go to the model
  task automatic push_words(input int len);
    logic [i3c_tx_pkg::DataWidth-1:0] w;
    int                               n_words;
    n_words = (len + 3) / 4;
    for (int i = 0; i < n_words; i++) begin
      w = next_rand();
      for (int b = 0; b < 4; b++) begin
        if (i * 4 + b < len) begin
          model_q.push_back(w[b*8 +: 8]);
        end
      end
      @(posedge clk_i);
      data_wvalid_i <= 1'b1;
      data_wdata_i  <= w;
      @(negedge clk_i);
      while (!data_wready_o) begin
        @(negedge clk_i);
      end
    end
    @(posedge clk_i);
    data_wvalid_i <= 1'b0;
  endtask

  task automatic run_transfer(input row_t row, input string name);
    int                               accepted;
    bit                               abort_sent;
    bit                               finished;
    logic [i3c_tx_pkg::ByteWidth-1:0] exp_byte;
    logic                             exp_last;
    accepted   = 0;
    abort_sent = 1'b0;
    finished   = 1'b0;
    push_descriptor(row.len);
    @(negedge clk_i);
    assert (tx_desc_avail_o) else report_failure(name, "descriptor not available after push");
    push_words(int'(row.len));
    @(posedge clk_i);
    tx_start_i <= 1'b1;
    @(posedge clk_i);
    tx_start_i <= 1'b0;
    @(negedge clk_i);
    assert (!tx_desc_avail_o) else report_failure(name, "descriptor not taken on start");

    while (!finished) begin
      @(posedge clk_i);
      if (!abort_sent && row.abort_after != 16'(NoAbort) &&
          accepted == int'(row.abort_after)) begin
        tx_abort_i      <= 1'b1;
        tx_byte_ready_i <= 1'b0;
        abort_sent      = 1'b1;
      end else begin
        tx_abort_i      <= 1'b0;
        tx_byte_ready_i <= int'(next_rand() % 32'd100) >= int'(row.stall_pct);
      end
      @(negedge clk_i);
      if (tx_byte_valid_o && tx_byte_ready_i) begin
        assert (!abort_sent) else report_failure(name, "byte accepted after abort");
        assert (model_q.size() > 0) else report_failure(name, "byte accepted beyond data");
        exp_byte = model_q.pop_front();
        accepted++;
        exp_last = accepted == int'(row.len);
        assert (tx_beat_o.data == exp_byte)
          else report_mismatch(name, "byte", 32'(exp_byte), 32'(tx_beat_o.data));
        assert (tx_beat_o.last == exp_last)
          else report_mismatch(name, "last flag", 32'(exp_last), 32'(tx_beat_o.last));
      end
      if (tx_end_o) begin
        finished = 1'b1;
        if (abort_sent) begin
          // Flushed bytes never reach the bus
          while (accepted < int'(row.len)) begin
            exp_byte = model_q.pop_front();
            accepted++;
          end
        end else begin
          assert (accepted == int'(row.len))
            else report_mismatch(name, "bytes accepted", 32'(row.len), accepted);
        end
      end
    end

    @(posedge clk_i);
    tx_byte_ready_i <= 1'b0;
    tx_abort_i      <= 1'b0;
    repeat (3) begin
      @(negedge clk_i);
      assert (!tx_end_o && !tx_byte_valid_o)
        else report_failure(name, "end or valid after the transfer finished");
    end
  endtask

  task automatic check_no_start(input string name);
    @(negedge clk_i);
    assert (!tx_desc_avail_o) else report_failure(name, "descriptor available unexpectedly");
    @(posedge clk_i);
    tx_start_i      <= 1'b1;
    tx_byte_ready_i <= 1'b1;
    repeat (WaitWindow) begin
      @(negedge clk_i);
      assert (!tx_byte_valid_o && !tx_end_o)
        else report_failure(name, "valid or end seen without a descriptor");
    end
    @(posedge clk_i);
    tx_start_i      <= 1'b0;
    tx_byte_ready_i <= 1'b0;
  endtask

  initial begin
    int limit;
    clk_i                 = 1'b0;
    rst_ni                = 1'b0;
    desc_wvalid_i         = 1'b0;
    desc_wdata_i          = '0;
    data_wvalid_i         = 1'b0;
    data_wdata_i          = '0;
    tx_start_i            = 1'b0;
    tx_abort_i            = 1'b0;
    recovery_mode_enter_i = 1'b0;
    tx_byte_ready_i       = 1'b0;
    rng_state             = 32'h2b6b_22c7;
    load_table();

    // Twenty cycles per byte of the table on top of a fixed margin
    limit = 2000;
    foreach (rows[i]) begin
      limit += 20 * int'(rows[i].len);
    end
    fork
      watchdog(limit);
    join_none

    repeat (ResetCycles) begin
      @(posedge clk_i);
    end
    rst_ni <= 1'b1;
    @(negedge clk_i);
    assert (!tx_byte_valid_o && !tx_end_o && !tx_desc_avail_o)
      else report_failure("reset", "bus side outputs not idle after reset");
    assert (desc_wready_o && data_wready_o)
      else report_failure("reset", "push ready low after reset");

    for (int r = 0; r < rows.size(); r++) begin
      if (rows[r].with_desc) begin
        run_transfer(rows[r], row_names[r]);
      end else begin
        check_no_start(row_names[r]);
      end
    end

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* filelist.f */
source/i3c_tx_pkg.sv
source/tx_desc_queue.sv
source/tx_data_queue.sv
source/descriptor_tx.sv
source/tti_tx_path.sv
verif/tti_tx_path_asserts.sv
verif/tb_tti_tx_path.sv

/* Makefile */
# Verilator build and run of the TTI TX path testbench

TOP := tb_tti_tx_path

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		-f filelist.f --top-module $(TOP) -o sim_$(TOP)

# Exit status of the simulation is the pass or fail result
run: build
	./obj_dir/sim_$(TOP)

lint:
	verilator --lint-only --timing -Wall -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir
